// File: verilog/icmp_pkg.sv
/* shared constants and the receive state encoding for the ICMP echo responder
   imported by the parser, FIFO and reply transmitter */
package icmp_pkg;

  // ------------------------------
  // ICMP field values
  // ------------------------------
  // type byte of an incoming echo request
  localparam logic [7:0] icmp_type_echo_request = 8'd8;
  // type byte sent back in the reply
  localparam logic [7:0] icmp_type_echo_reply = 8'd0;
  // destination unreachable, reported to the host
  localparam logic [7:0] icmp_type_unreachable = 8'd3;
  // only code 0 is accepted for echo
  localparam logic [7:0] icmp_code_zero = 8'd0;

  // ------------------------------
  // sizes
  // ------------------------------
  // type, code and two checksum bytes
  localparam logic [15:0] icmp_header_len = 16'd4;
  // payload buffer capacity in bytes
  localparam int payload_depth = 64;
  localparam int payload_addr_w = $clog2(payload_depth);
  // header bytes put out ahead of the payload
  localparam logic [2:0] tx_hdr_len = 3'd4;

  // receive FSM states
  typedef enum logic [2:0] {
    idle,
    header,
    payload,
    reply_wait,
    reply_busy,
    discard,
    unreachable
  } rx_state_t;

endpackage

// File: verilog/icmp_payload_fifo.sv
/* byte FIFO that holds the echo payload until the reply goes out
   read_data shows the head byte whenever the FIFO is not empty */
`timescale 1ns/10ps

module icmp_payload_fifo
  import icmp_pkg::*;
(
  input  logic       rx_clock,
  input  logic       arst_n,
  input  logic       clear,
  input  logic       write,
  input  logic [7:0] write_data,
  input  logic       read,
  output logic [7:0] read_data,
  output logic       full,
  output logic       empty
);

  logic [7:0] mem [payload_depth];
  // one extra bit tells full from empty
  logic [payload_addr_w:0] wr_ptr;
  logic [payload_addr_w:0] rd_ptr;
  logic do_write;
  logic do_read;

  assign do_write = write && !full;
  assign do_read  = read && !empty;

  assign empty = (wr_ptr == rd_ptr);
  // same slot, opposite lap
  assign full  = (wr_ptr[payload_addr_w] != rd_ptr[payload_addr_w]) &&
                 (wr_ptr[payload_addr_w-1:0] == rd_ptr[payload_addr_w-1:0]);

  // read ahead, no extra latency
  assign read_data = mem[rd_ptr[payload_addr_w-1:0]];

  // ------------------------------
  // pointers
  // ------------------------------
  always_ff @(posedge rx_clock or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else if (clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_write) wr_ptr <= wr_ptr + 1'b1;
      if (do_read) rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // storage
  always_ff @(posedge rx_clock) begin
    if (do_write) mem[wr_ptr[payload_addr_w-1:0]] <= write_data;
  end

endmodule

// File: verilog/icmp_checksum.sv
/* running ones' complement sum of the payload
   gives the checksum for a reply with type 0 and code 0 */
`timescale 1ns/10ps

module icmp_checksum (
  input  logic        rx_clock,
  input  logic        arst_n,
  input  logic        clear,
  input  logic        add,
  input  logic        odd_byte,
  input  logic [7:0]  data,
  output logic [15:0] checksum
);

  // carries pile up in the top half
  logic [31:0] sum;

  always_ff @(posedge rx_clock or negedge arst_n) begin
    if (!arst_n) begin
      sum <= '0;
    end else if (clear) begin
      sum <= '0;
    end else if (add) begin
      // even byte is the high half of a word
      if (odd_byte) sum <= sum + {24'd0, data};
      else sum <= sum + {16'd0, data, 8'd0};
    end
  end

  // ------------------------------
  // fold carries once and invert
  // ------------------------------
  // reply header fields are all zero so only the payload counts
  assign checksum = ~(sum[15:0] + sum[31:16]);

endmodule

// File: verilog/icmp_rx_parser.sv
/* receive FSM: classifies each ICMP message, captures the sender addresses
   and steers echo payload bytes into the FIFO and checksum */
`timescale 1ns/10ps

module icmp_rx_parser
  import icmp_pkg::*;
(
  input  logic        rx_clock,
  input  logic        arst_n,
  input  logic        rx_enable,
  input  logic [7:0]  rx_data,
  input  logic [47:0] remote_mac,
  input  logic [31:0] remote_ip,
  input  logic        fifo_full,
  input  logic        sending,
  output logic        payload_write,
  output logic        payload_clear,
  output logic        payload_odd,
  output logic        reply_pending,
  output logic        tx_request,
  output logic        dst_unreachable,
  output logic [15:0] length,
  output logic [47:0] destination_mac,
  output logic [31:0] destination_ip
);

  rx_state_t  state;
  // header bytes still to come after the type byte
  logic [1:0] byte_no;
  logic       oversize;

  // buffer exhausted, either by the FIFO flag or by the byte count
  assign oversize = fifo_full || (length >= icmp_header_len + 16'(payload_depth));

  assign payload_write = rx_enable && (state == payload);
  // FIFO and checksum start fresh for every message
  assign payload_clear = (state == idle);
  // byte position inside the 16-bit word
  assign payload_odd   = length[0];
  assign tx_request    = (state == reply_wait);
  assign reply_pending = (state == reply_wait) || (state == reply_busy);

  // ------------------------------
  // state machine
  // ------------------------------
  always_ff @(posedge rx_clock or negedge arst_n) begin
    if (!arst_n) begin
      state           <= idle;
      byte_no         <= '0;
      dst_unreachable <= 1'b0;
    end else begin
      // single cycle flag
      dst_unreachable <= 1'b0;
      case (state)
        idle: begin
          // first byte of a message is the type
          if (rx_enable) begin
            byte_no <= 2'(icmp_header_len - 16'd2);
            if (rx_data == icmp_type_unreachable) state <= unreachable;
            else if (rx_data == icmp_type_echo_request) state <= header;
            else state <= discard;
          end
        end
        header: begin
          // message ended inside the header
          if (!rx_enable) state <= idle;
          // code byte must be zero
          else if ((byte_no == 2'd2) && (rx_data != icmp_code_zero)) state <= discard;
          else if (byte_no == 2'd0) state <= payload;
          else byte_no <= byte_no - 2'd1;
        end
        payload: begin
          if (!rx_enable) state <= reply_wait;
          else if (oversize) state <= discard;
        end
        // hold the request until the transmitter takes it
        reply_wait: if (sending) state <= reply_busy;
        reply_busy: if (!sending) state <= idle;
        unreachable: begin
          dst_unreachable <= 1'b1;
          state           <= discard;
        end
        // swallow the rest of a dropped message
        discard: if (!rx_enable) state <= idle;
        default: state <= idle;
      endcase
    end
  end

  // ------------------------------
  // captured message fields
  // ------------------------------
  always_ff @(posedge rx_clock) begin
    // reply goes back to the sender
    if ((state == idle) && rx_enable) begin
      destination_mac <= remote_mac;
      destination_ip  <= remote_ip;
    end
    // count starts at the header size and grows per payload byte
    if ((state == header) && rx_enable && (byte_no == 2'd0)) length <= icmp_header_len;
    else if (payload_write) length <= length + 16'd1;
  end

endmodule

// File: verilog/icmp_reply_tx.sv
/* echo reply transmitter: after the grant it puts out type, code and checksum,
   then the buffered payload, one byte per cycle on tx_data */
`timescale 1ns/10ps

module icmp_reply_tx
  import icmp_pkg::*;
(
  input  logic        rx_clock,
  input  logic        arst_n,
  input  logic        tx_enable,
  input  logic        reply_pending,
  input  logic [15:0] checksum,
  input  logic [7:0]  fifo_data,
  input  logic        fifo_empty,
  output logic        sending,
  output logic        tx_active,
  output logic [7:0]  tx_data,
  output logic        fifo_read
);

  // header bytes already sent
  logic [2:0] hdr_cnt;
  // blocks a second grant while the parser is still in reply_busy
  logic       reply_done;
  logic       hdr_phase;

  assign hdr_phase = sending && (hdr_cnt != tx_hdr_len);
  // pop one byte per cycle once the header is out
  assign fifo_read = sending && (hdr_cnt == tx_hdr_len) && !fifo_empty;

  // ------------------------------
  // control
  // ------------------------------
  always_ff @(posedge rx_clock or negedge arst_n) begin
    if (!arst_n) begin
      sending    <= 1'b0;
      tx_active  <= 1'b0;
      hdr_cnt    <= '0;
      reply_done <= 1'b0;
    end else if (!sending) begin
      hdr_cnt   <= '0;
      tx_active <= 1'b0;
      // parser back in idle, ready for the next reply
      if (!reply_pending) reply_done <= 1'b0;
      else if (tx_enable && !reply_done) sending <= 1'b1;
    end else if (hdr_phase) begin
      hdr_cnt   <= hdr_cnt + 3'd1;
      tx_active <= 1'b1;
    end else if (!fifo_empty) begin
      tx_active <= 1'b1;
    end else begin
      // last payload byte is on the bus now
      sending    <= 1'b0;
      tx_active  <= 1'b0;
      reply_done <= 1'b1;
    end
  end

  // ------------------------------
  // output byte
  // ------------------------------
  always_ff @(posedge rx_clock) begin
    if (hdr_phase) begin
      case (hdr_cnt)
        3'd0: tx_data <= icmp_type_echo_reply;
        3'd1: tx_data <= icmp_code_zero;
        3'd2: tx_data <= checksum[15:8];
        default: tx_data <= checksum[7:0];
      endcase
    end else if (fifo_read) begin
      tx_data <= fifo_data;
    end
  end

endmodule

// File: verilog/icmp_responder.sv
/* top level of the ICMP echo responder, one clock for receive and send
   wires the parser, payload FIFO, checksum and reply transmitter together */
`timescale 1ns/10ps

module icmp_responder (
  input  logic        rx_clock,
  input  logic        arst_n,
  input  logic        rx_enable,
  input  logic [7:0]  rx_data,
  input  logic [47:0] remote_mac,
  input  logic [31:0] remote_ip,
  input  logic        tx_enable,
  output logic        dst_unreachable,
  output logic        tx_request,
  output logic        tx_active,
  output logic [7:0]  tx_data,
  output logic [15:0] length,
  output logic [47:0] destination_mac,
  output logic [31:0] destination_ip
);

  // parser to FIFO and checksum
  logic        payload_write;
  logic        payload_clear;
  logic        payload_odd;
  logic        fifo_full;
  // FIFO and checksum to transmitter
  logic [15:0] checksum;
  logic [7:0]  fifo_data;
  logic        fifo_empty;
  logic        fifo_read;
  // reply handshake between parser and transmitter
  logic        reply_pending;
  logic        sending;

  // ------------------------------
  // receive side
  // ------------------------------
  // reply_pending covers the reply_wait and reply_busy states of rx_state_t
  icmp_rx_parser u_parser (
    .rx_clock        (rx_clock),
    .arst_n          (arst_n),
    .rx_enable       (rx_enable),
    .rx_data         (rx_data),
    .remote_mac      (remote_mac),
    .remote_ip       (remote_ip),
    .fifo_full       (fifo_full),
    .sending         (sending),
    .payload_write   (payload_write),
    .payload_clear   (payload_clear),
    .payload_odd     (payload_odd),
    .reply_pending   (reply_pending),
    .tx_request      (tx_request),
    .dst_unreachable (dst_unreachable),
    .length          (length),
    .destination_mac (destination_mac),
    .destination_ip  (destination_ip)
  );

  // payload bytes go to FIFO and checksum side by side
  icmp_payload_fifo u_fifo (
    .rx_clock   (rx_clock),
    .arst_n     (arst_n),
    .clear      (payload_clear),
    .write      (payload_write),
    .write_data (rx_data),
    .read       (fifo_read),
    .read_data  (fifo_data),
    .full       (fifo_full),
    .empty      (fifo_empty)
  );

  icmp_checksum u_checksum (
    .rx_clock (rx_clock),
    .arst_n   (arst_n),
    .clear    (payload_clear),
    .add      (payload_write),
    .odd_byte (payload_odd),
    .data     (rx_data),
    .checksum (checksum)
  );

  // ------------------------------
  // send side
  // ------------------------------
  icmp_reply_tx u_reply_tx (
    .rx_clock      (rx_clock),
    .arst_n        (arst_n),
    .tx_enable     (tx_enable),
    .reply_pending (reply_pending),
    .checksum      (checksum),
    .fifo_data     (fifo_data),
    .fifo_empty    (fifo_empty),
    .sending       (sending),
    .tx_active     (tx_active),
    .tx_data       (tx_data),
    .fifo_read     (fifo_read)
  );

endmodule

// File: testbench/icmp_tb.sv
/* testbench for the ICMP echo responder that sends echo, unreachable and malformed
   messages and checks replies against a reference model */
`timescale 1ns/10ps

module icmp_tb
  import icmp_pkg::*;
();

  localparam int num_echo = 6;
  // requests plus replies on the wire with margin for the dropped ones
  localparam int num_packets = 2 * (num_echo + 1) + 5;
  localparam int max_cycles = 8 + num_packets * (payload_depth + 40);

  logic        rx_clock;
  logic        arst_n;
  logic        rx_enable;
  logic [7:0]  rx_data;
  logic [47:0] remote_mac;
  logic [31:0] remote_ip;
  logic        tx_enable;
  logic        dst_unreachable;
  logic        tx_request;
  logic        tx_active;
  logic [7:0]  tx_data;
  logic [15:0] length;
  logic [47:0] destination_mac;
  logic [31:0] destination_ip;

  logic [31:0] rng_state = 32'd68375;
  // set while the current message may legally produce a reply or a flag
  logic        reply_allowed;
  logic        unreach_allowed;
  int          pulse_count = 0;

  icmp_responder dut (.*);

  initial begin
    rx_clock = 1'b0;
    forever #20 rx_clock = ~rx_clock;
  end

  // ------------------------------
  // helpers
  // ------------------------------
  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic check_hex(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp)
      else stop_run($sformatf("** Error %s: got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  // xorshift32
  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // payload summed as big-endian 16-bit words with one fold and then inverted
  function automatic logic [15:0] expected_checksum(input logic [7:0] data[$]);
    logic [31:0] sum;
    logic [15:0] word;
    logic [15:0] folded;
    sum = '0;
    for (int i = 0; i < data.size(); i += 2) begin
      // odd length pads the last word with a zero low byte
      word = {data[i], (i + 1 < data.size()) ? data[i + 1] : 8'h00};
      sum  = sum + {16'd0, word};
    end
    folded = sum[15:0] + sum[31:16];
    return ~folded;
  endfunction

  task automatic drive_message(input logic [7:0] bytes[$], input logic [47:0] mac,
                               input logic [31:0] ip);
    foreach (bytes[i]) begin
      @(posedge rx_clock);
      #2;
      rx_enable  = 1'b1;
      rx_data    = bytes[i];
      // addresses only count at the first byte and are junk afterwards
      remote_mac = (i == 0) ? mac : ~mac;
      remote_ip  = (i == 0) ? ip : ~ip;
    end
    @(posedge rx_clock);
    #2;
    rx_enable = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge rx_clock);
    #2;
  endtask

  // message that must not be answered
  // total counts the header bytes too
  task automatic send_dropped(input logic [7:0] msg_type, input logic [7:0] code, input int total);
    logic [7:0]  bytes[$];
    logic [63:0] r64;
    for (int i = 0; i < total; i++) begin
      if (i == 0) bytes.push_back(msg_type);
      else if (i == 1) bytes.push_back(code);
      else bytes.push_back(8'(next_random()));
    end
    r64 = {next_random(), next_random()};
    drive_message(bytes, r64[47:0], r64[63:32]);
    idle_cycles(4);
  endtask

  // ------------------------------
  // echo request and reply check
  // ------------------------------
  task automatic run_echo(input int n);
    logic [7:0]  payload[$];
    logic [7:0]  msg[$];
    logic [7:0]  reply[$];
    logic [63:0] r64;
    logic [15:0] cs;
    int          grant_wait;
    int          idx;
    for (int i = 0; i < n; i++) payload.push_back(8'(next_random()));
    cs    = expected_checksum(payload);
    reply = {icmp_type_echo_reply, icmp_code_zero, cs[15:8], cs[7:0]};
    // incoming checksum is never verified so random bytes do
    msg   = {icmp_type_echo_request, icmp_code_zero, 8'(next_random()), 8'(next_random())};
    foreach (payload[i]) begin
      msg.push_back(payload[i]);
      reply.push_back(payload[i]);
    end
    r64 = {next_random(), next_random()};
    grant_wait = int'(next_random() & 32'd7);
    reply_allowed = 1'b1;
    drive_message(msg, r64[47:0], r64[63:32]);
    // parser enters reply_wait on this edge
    @(posedge rx_clock);
    @(negedge rx_clock);
    check_hex("length", 64'(length), 64'(n + 4));
    check_hex("destination_mac", 64'(destination_mac), 64'(r64[47:0]));
    check_hex("destination_ip", 64'(destination_ip), 64'(r64[63:32]));
    repeat (grant_wait) begin
      check_hex("tx_request", 64'(tx_request), 64'd1);
      @(negedge rx_clock);
    end
    @(posedge rx_clock);
    #2;
    tx_enable = 1'b1;
    // grant not sampled yet
    @(negedge rx_clock);
    check_hex("tx_request", 64'(tx_request), 64'd1);
    idx = 0;
    while (!tx_active) begin
      idx++;
      if (idx > 4) stop_run("no reply started after tx_enable was granted");
      @(negedge rx_clock);
    end
    idx = 0;
    while (tx_active) begin
      if (idx >= reply.size()) stop_run("tx_active held past the end of the reply");
      check_hex($sformatf("tx_data[%0d]", idx), 64'(tx_data), 64'(reply[idx]));
      idx++;
      @(negedge rx_clock);
    end
    check_hex("tx_active cycles", 64'(idx), 64'(n + 4));
    @(posedge rx_clock);
    #2;
    tx_enable = 1'b0;
    // parser back in idle before the next message
    idle_cycles(3);
    reply_allowed = 1'b0;
  endtask

  // ------------------------------
  // assertions
  // ------------------------------
  always @(negedge rx_clock) begin
    if (dst_unreachable) pulse_count <= pulse_count + 1;
  end

  a_request_only_echo: assert property (@(posedge rx_clock) disable iff (!arst_n)
    tx_request |-> reply_allowed)
    else stop_run("tx_request raised for a message that gets no reply");

  a_active_only_echo: assert property (@(posedge rx_clock) disable iff (!arst_n)
    tx_active |-> reply_allowed)
    else stop_run("tx_active raised for a message that gets no reply");

  a_unreach_only_type3: assert property (@(posedge rx_clock) disable iff (!arst_n)
    dst_unreachable |-> unreach_allowed)
    else stop_run("dst_unreachable raised outside a type 3 message");

  a_unreach_pulse: assert property (@(posedge rx_clock) disable iff (!arst_n)
    dst_unreachable |=> !dst_unreachable)
    else stop_run("dst_unreachable held for more than one cycle");

  // ------------------------------
  // stimulus
  // ------------------------------
  initial begin
    int start_count;
    arst_n          = 1'b0;
    rx_enable       = 1'b0;
    rx_data         = '0;
    remote_mac      = '0;
    remote_ip       = '0;
    tx_enable       = 1'b0;
    reply_allowed   = 1'b0;
    unreach_allowed = 1'b0;
    repeat (7) @(posedge rx_clock);
    @(negedge rx_clock);
    check_hex("tx_request", 64'(tx_request), 64'd0);
    check_hex("tx_active", 64'(tx_active), 64'd0);
    check_hex("dst_unreachable", 64'(dst_unreachable), 64'd0);
    @(posedge rx_clock);
    #2;
    arst_n = 1'b1;
    // outputs must stay low on a quiet line
    idle_cycles(6);
    repeat (num_echo) run_echo(1 + int'(next_random() % 32'd60));
    // destination unreachable gives a single flag
    unreach_allowed = 1'b1;
    start_count = pulse_count;
    send_dropped(icmp_type_unreachable, icmp_code_zero, 10);
    check_hex("dst_unreachable pulses", 64'(pulse_count - start_count), 64'd1);
    unreach_allowed = 1'b0;
    // timestamp type, bad code, cut short, too long
    send_dropped(8'h0d, icmp_code_zero, 12);
    send_dropped(icmp_type_echo_request, 8'h01, 12);
    send_dropped(icmp_type_echo_request, icmp_code_zero, 3);
    send_dropped(icmp_type_echo_request, icmp_code_zero, 4 + payload_depth + 6);
    run_echo(1 + int'(next_random() % 32'd60));
    $display("No errors");
    $finish;
  end

  // watchdog
  initial begin
    repeat (max_cycles) @(posedge rx_clock);
    stop_run("watchdog expired before all messages were handled");
  end

endmodule

// File: sources.f
verilog/icmp_pkg.sv
verilog/icmp_payload_fifo.sv
verilog/icmp_checksum.sv
verilog/icmp_rx_parser.sv
verilog/icmp_reply_tx.sv
verilog/icmp_responder.sv
testbench/icmp_tb.sv

// File: run_sim.sh
#!/bin/bash
# Build the ICMP responder testbench with Verilator, run it and check the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module icmp_tb \
  -f sources.f --Mdir obj_dir -o icmp_tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/icmp_tb_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
fi

if grep -q "^No errors$" sim.log; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi
